// ==== design/cdb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cdb #(
    parameter int num_fu    = 6,
    parameter int cdb_ports = 2
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,

    // arbitration, grant is same-cycle combinational
    input  wire logic [num_fu-1:0]                    fu_requests, // slot 0 first
    output logic [num_fu-1:0]                         fu_grants,   // slot drives next cycle

    // granted slots present their entries the cycle after the grant
    input  wire cdb_pkg::cdb_entry_t [num_fu-1:0]     fu_outputs,

    // wakeup hint, one cycle ahead of the bus
    output cdb_pkg::early_tag_t [cdb_ports-1:0]       early_tags,

    // registered broadcast to the register file
    output cdb_pkg::cdb_entry_t [cdb_ports-1:0]       cdb_output
);

    logic [cdb_ports-1:0][num_fu-1:0] gnt_bus_next; // this cycle's per-port grants
    logic [cdb_ports-1:0][num_fu-1:0] gnt_bus;      // last cycle's, picks the drivers

    cdb_pkg::cdb_entry_t [cdb_ports-1:0] cdb_next;  // selected entries
    cdb_pkg::cdb_entry_t [cdb_ports-1:0] cdb_q;     // broadcast stage

    psel_gen #(
        .num_fu    (num_fu),
        .cdb_ports (cdb_ports)
    ) i_psel_gen (
        .req     (fu_requests),
        .gnt     (fu_grants),
        .gnt_bus (gnt_bus_next)
    );

    // or-mux per port
    // non-driving slots are zero, grant vector at most one-hot
    always_comb begin
        cdb_next = '0;
        for (int p = 0; p < cdb_ports; p++) begin
            for (int j = 0; j < num_fu; j++) begin
                if (gnt_bus[p][j]) cdb_next[p] = cdb_next[p] | fu_outputs[j];
            end
        end
    end

    // early tags straight from the mux
    always_comb begin
        for (int p = 0; p < cdb_ports; p++) begin
            early_tags[p].valid = cdb_next[p].valid;
            early_tags[p].tag   = cdb_next[p].tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            gnt_bus <= '0;
            cdb_q   <= '0; // no valid ports out of reset
        end else begin
            gnt_bus <= gnt_bus_next;
            cdb_q   <= cdb_next;
        end
    end

    assign cdb_output = cdb_q;

endmodule

`default_nettype wire

// ==== design/cdb_pkg.sv ====
`default_nettype none

package cdb_pkg;

    // physical register tag, 64 regs
    localparam int tag_width = 6;

    // result value width
    localparam int data_width = 32;

    // size of the physical register file
    localparam int num_phys_regs = 64;

    // what a functional unit hands over with its strobe
    typedef struct packed {
        logic [tag_width-1:0]  tag;  // destination phys reg
        logic [data_width-1:0] data; // result value
    } fu_result_t;                   // 38 bits

    // one bus port, also one slot's driven output
    typedef struct packed {
        logic                  valid; // port carries a result
        logic [tag_width-1:0]  tag;   // phys reg being written
        logic [data_width-1:0] data;  // value written
    } cdb_entry_t;                    // 39 bits

    // tag announced a cycle before the bus carries it
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
    } early_tag_t; // 7 bits

    // result slot life cycle
    // empty -> waiting on strobe, waiting -> driving on grant,
    // driving -> empty after one cycle on the bus
    typedef enum logic [1:0] {
        slot_empty   = 2'd0, // nothing held
        slot_waiting = 2'd1, // holding, requesting the bus
        slot_driving = 2'd2  // granted, entry presented to cdb
    } slot_state_e;

endpackage

`default_nettype wire

// ==== design/cdb_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module cdb_top #(
    parameter int num_fu    = 6, // branch, mult, 3 alu, mem
    parameter int cdb_ports = 2
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,

    // results from the execution units
    input  wire logic [num_fu-1:0]                    fu_strobe,
    input  wire cdb_pkg::fu_result_t [num_fu-1:0]     fu_result,
    output logic [num_fu-1:0]                         overflow,

    // bus view
    output cdb_pkg::early_tag_t [cdb_ports-1:0]       early_tags,
    output cdb_pkg::cdb_entry_t [cdb_ports-1:0]       cdb_output,

    // register file side
    input  wire logic                                 alloc_strobe,
    input  wire logic [cdb_pkg::tag_width-1:0]        alloc_tag,
    input  wire logic [cdb_pkg::tag_width-1:0]        read_tag,
    output logic [cdb_pkg::data_width-1:0]            read_data,
    output logic                                      read_ready
);

    logic [num_fu-1:0]                  fu_requests; // slot waiting
    logic [num_fu-1:0]                  fu_grants;   // slot wins a port
    cdb_pkg::cdb_entry_t [num_fu-1:0]   fu_outputs;  // driving entries

    // producer
    fu_result_slots #(
        .num_fu (num_fu)
    ) i_fu_result_slots (
        .clock       (clock),
        .reset       (reset),
        .fu_strobe   (fu_strobe),
        .fu_result   (fu_result),
        .fu_grants   (fu_grants),
        .fu_requests (fu_requests),
        .fu_outputs  (fu_outputs),
        .overflow    (overflow)
    );

    // arbiter plus broadcast stage
    cdb #(
        .num_fu    (num_fu),
        .cdb_ports (cdb_ports)
    ) i_cdb (
        .clock       (clock),
        .reset       (reset),
        .fu_requests (fu_requests),
        .fu_grants   (fu_grants),
        .fu_outputs  (fu_outputs),
        .early_tags  (early_tags),
        .cdb_output  (cdb_output)
    );

    // consumer
    phys_reg_file #(
        .cdb_ports (cdb_ports)
    ) i_phys_reg_file (
        .clock        (clock),
        .reset        (reset),
        .cdb_output   (cdb_output),
        .alloc_strobe (alloc_strobe),
        .alloc_tag    (alloc_tag),
        .read_tag     (read_tag),
        .read_data    (read_data),
        .read_ready   (read_ready)
    );

endmodule

`default_nettype wire

// ==== design/fu_result_slots.sv ====
`default_nettype none
`timescale 1ns/1ps

module fu_result_slots #(
    parameter int num_fu = 6
) (
    input  wire logic                                clock,
    input  wire logic                                reset,

    // one single-cycle strobe per unit, no back-pressure
    input  wire logic [num_fu-1:0]                   fu_strobe,
    input  wire cdb_pkg::fu_result_t [num_fu-1:0]    fu_result,

    // arbiter handshake
    input  wire logic [num_fu-1:0]                   fu_grants,
    output logic [num_fu-1:0]                        fu_requests,

    // entries toward the cdb mux, zero unless driving
    output cdb_pkg::cdb_entry_t [num_fu-1:0]         fu_outputs,

    // sticky, one bit per slot
    output logic [num_fu-1:0]                        overflow
);

    cdb_pkg::slot_state_e state [num_fu]; // per-slot fsm
    cdb_pkg::fu_result_t  held  [num_fu]; // payload, one entry per unit

    logic [num_fu-1:0] slot_free; // slot can take a strobe this cycle
    logic [num_fu-1:0] accept;    // strobe lands in an empty slot
    logic [num_fu-1:0] dropped;   // strobe hits a busy slot

    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            slot_free[i] = (state[i] == cdb_pkg::slot_empty);
        end
    end

    assign accept  = fu_strobe & slot_free;
    assign dropped = fu_strobe & ~slot_free;

    // slot fsm and overflow flags
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_fu; i++) begin
                state[i] <= cdb_pkg::slot_empty;
            end
            overflow <= '0;
        end else begin
            for (int i = 0; i < num_fu; i++) begin
                case (state[i])
                    cdb_pkg::slot_empty: begin
                        if (accept[i]) state[i] <= cdb_pkg::slot_waiting;
                    end
                    cdb_pkg::slot_waiting: begin
                        // loser keeps requesting
                        if (fu_grants[i]) state[i] <= cdb_pkg::slot_driving;
                    end
                    cdb_pkg::slot_driving: begin
                        state[i] <= cdb_pkg::slot_empty; // one cycle on the mux
                    end
                    default: begin
                        state[i] <= cdb_pkg::slot_empty;
                    end
                endcase
            end
            overflow <= overflow | dropped; // stays set until reset
        end
    end

    // result capture, only on accept
    always_ff @(posedge clock) begin
        for (int i = 0; i < num_fu; i++) begin
            if (accept[i]) held[i] <= fu_result[i];
        end
    end

    // request while waiting, entry while driving
    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            fu_requests[i] = (state[i] == cdb_pkg::slot_waiting);
            fu_outputs[i]  = '0;
            if (state[i] == cdb_pkg::slot_driving) begin
                fu_outputs[i].valid = 1'b1;
                fu_outputs[i].tag   = held[i].tag;
                fu_outputs[i].data  = held[i].data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/phys_reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module phys_reg_file #(
    parameter int cdb_ports = 2
) (
    input  wire logic                                  clock,
    input  wire logic                                  reset,

    // write-back from the bus
    input  wire cdb_pkg::cdb_entry_t [cdb_ports-1:0]   cdb_output,

    // rename allocation, marks the tag not ready
    input  wire logic                                  alloc_strobe,
    input  wire logic [cdb_pkg::tag_width-1:0]         alloc_tag,

    // combinational read port
    input  wire logic [cdb_pkg::tag_width-1:0]         read_tag,
    output logic [cdb_pkg::data_width-1:0]             read_data,
    output logic                                       read_ready
);

    logic [cdb_pkg::data_width-1:0] reg_data [cdb_pkg::num_phys_regs];
    logic [cdb_pkg::num_phys_regs-1:0] ready; // value present

    logic alloc_wr_hit; // a bus port writes the tag being allocated

    always_comb begin
        alloc_wr_hit = 1'b0;
        for (int p = 0; p < cdb_ports; p++) begin
            if (cdb_output[p].valid && (cdb_output[p].tag == alloc_tag)) begin
                alloc_wr_hit = 1'b1;
            end
        end
    end

    // ready bits
    // bus write beats allocation on the same tag
    always_ff @(posedge clock) begin
        if (reset) begin
            ready <= '1; // everything ready after reset
        end else begin
            if (alloc_strobe && !alloc_wr_hit) begin
                ready[alloc_tag] <= 1'b0;
            end
            for (int p = 0; p < cdb_ports; p++) begin
                if (cdb_output[p].valid) ready[cdb_output[p].tag] <= 1'b1;
            end
        end
    end

    // data array, cleared to zero on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < cdb_pkg::num_phys_regs; r++) begin
                reg_data[r] <= '0;
            end
        end else begin
            for (int p = 0; p < cdb_ports; p++) begin
                // ports never carry the same tag
                if (cdb_output[p].valid) begin
                    reg_data[cdb_output[p].tag] <= cdb_output[p].data;
                end
            end
        end
    end

    // no bypass, a write shows up the cycle after it lands
    assign read_data  = reg_data[read_tag];
    assign read_ready = ready[read_tag];

endmodule

`default_nettype wire

// ==== design/psel_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module psel_gen #(
    parameter int num_fu    = 6,
    parameter int cdb_ports = 2
) (
    input  wire logic [num_fu-1:0]                 req,     // bit 0 highest priority
    output logic [num_fu-1:0]                      gnt,     // any port granted
    output logic [cdb_ports-1:0][num_fu-1:0]       gnt_bus  // one-hot or zero per port
);

    logic [num_fu-1:0] taken; // requests claimed by earlier ports
    logic              found; // current port already has a winner

    // port order matters, each port sees what earlier ports left over
    // even ports scan from index 0 up, odd ports from the top down
    always_comb begin
        gnt_bus = '0;
        taken   = '0;
        found   = 1'b0;
        for (int p = 0; p < cdb_ports; p++) begin
            found = 1'b0;
            if ((p % 2) == 0) begin
                // low end first
                for (int i = 0; i < num_fu; i++) begin
                    if (!found && req[i] && !taken[i]) begin
                        gnt_bus[p][i] = 1'b1;
                        found         = 1'b1;
                    end
                end
            end else begin
                // high end first
                for (int i = num_fu - 1; i >= 0; i--) begin
                    if (!found && req[i] && !taken[i]) begin
                        gnt_bus[p][i] = 1'b1;
                        found         = 1'b1;
                    end
                end
            end
            taken = taken | gnt_bus[p]; // single request stays on port 0
        end
    end

    // grant back to the slots, or of all ports
    always_comb begin
        gnt = '0;
        for (int p = 0; p < cdb_ports; p++) begin
            gnt = gnt | gnt_bus[p];
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/cdb_pkg.sv
design/fu_result_slots.sv
design/psel_gen.sv
design/cdb.sv
design/phys_reg_file.sv
design/cdb_top.sv
tb/cdb_assertions.sv
tb/cdb_tb.sv

// ==== tb/cdb_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

module cdb_assertions #(
    parameter int num_fu    = 6,
    parameter int cdb_ports = 2
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic [cdb_ports-1:0][num_fu-1:0]     gnt_bus,    // this cycle's grants
    input  wire cdb_pkg::early_tag_t [cdb_ports-1:0]  early_tags,
    input  wire cdb_pkg::cdb_entry_t [cdb_ports-1:0]  cdb_output
);

    int failures = 0; // failed checks so far

    logic [num_fu-1:0] claimed; // slots taken by lower ports
    logic              double;  // one slot on two ports

    always_comb begin
        claimed = '0;
        double  = 1'b0;
        for (int p = 0; p < cdb_ports; p++) begin
            double  = double | (|(claimed & gnt_bus[p]));
            claimed = claimed | gnt_bus[p];
        end
    end

    single_grant: assert property (@(posedge clock) disable iff (reset) !double)
        else begin
            $error("slot granted to more than one bus port");
            failures++;
        end

    // two writes in one cycle never target the same register
    distinct_tags: assert property (@(posedge clock) disable iff (reset)
        (cdb_output[0].valid && cdb_output[1].valid) |-> (cdb_output[0].tag != cdb_output[1].tag))
        else begin
            $error("both bus ports carry the same tag");
            failures++;
        end

    for (genvar p = 0; p < cdb_ports; p++) begin : g_port
        // early tag leads the bus by exactly one cycle
        early_leads_bus: assert property (@(posedge clock) disable iff (reset)
            1'b1 |=> ({cdb_output[p].valid, cdb_output[p].tag} == $past(early_tags[p])))
            else begin
                $error("bus port %0d does not match last cycle's early tag", p);
                failures++;
            end
    end

endmodule

bind cdb cdb_assertions #(
    .num_fu    (num_fu),
    .cdb_ports (cdb_ports)
) i_cdb_assertions (
    .clock      (clock),
    .reset      (reset),
    .gnt_bus    (gnt_bus_next),
    .early_tags (early_tags),
    .cdb_output (cdb_output)
);

`default_nettype wire

// ==== tb/cdb_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cdb_tb;

    localparam int num_fu        = 6;
    localparam int cdb_ports     = 2;
    localparam int reset_cycles  = 3;
    localparam int random_cycles = 400;
    // latency 10, drain 14, overflow 10, alloc 20, random plus drain, slack
    localparam int max_cycles    = reset_cycles + 10 + 14 + 10 + 20 + random_cycles + 12 + 100;

    logic                                  clock;
    logic                                  reset;
    logic [num_fu-1:0]                     fu_strobe;
    cdb_pkg::fu_result_t [num_fu-1:0]      fu_result;
    logic [num_fu-1:0]                     overflow;
    cdb_pkg::early_tag_t [cdb_ports-1:0]   early_tags;
    cdb_pkg::cdb_entry_t [cdb_ports-1:0]   cdb_output;
    logic                                  alloc_strobe;
    logic [cdb_pkg::tag_width-1:0]         alloc_tag;
    logic [cdb_pkg::tag_width-1:0]         read_tag;
    logic [cdb_pkg::data_width-1:0]        read_data;
    logic                                  read_ready;

    int errors;
    int checks;
    int tests;
    int cycles;

    // reference state as it stands after the last rising edge
    cdb_pkg::slot_state_e              m_state [num_fu];
    cdb_pkg::fu_result_t               m_held [num_fu];
    logic [num_fu-1:0]                 m_ovf;
    int                                m_port_slot [cdb_ports]; // driving slot, -1 if none
    cdb_pkg::cdb_entry_t               m_bus [cdb_ports];       // registered broadcast
    logic [cdb_pkg::data_width-1:0]    m_data [cdb_pkg::num_phys_regs];
    logic [cdb_pkg::num_phys_regs-1:0] m_rdy;

    cdb_top #(
        .num_fu    (num_fu),
        .cdb_ports (cdb_ports)
    ) i_cdb_top (
        .clock        (clock),
        .reset        (reset),
        .fu_strobe    (fu_strobe),
        .fu_result    (fu_result),
        .overflow     (overflow),
        .early_tags   (early_tags),
        .cdb_output   (cdb_output),
        .alloc_strobe (alloc_strobe),
        .alloc_tag    (alloc_tag),
        .read_tag     (read_tag),
        .read_data    (read_data),
        .read_ready   (read_ready)
    );

    always #10 clock = ~clock; // 20 ns period

    // port 0 takes the lowest waiting slot, port 1 the highest one left
    function automatic void pick_slots(input logic [num_fu-1:0] req,
                                       output int low, output int high);
        low  = -1;
        high = -1;
        for (int i = num_fu - 1; i >= 0; i--) begin
            if (req[i]) low = i; // last hit is the lowest
        end
        for (int i = 0; i < num_fu; i++) begin
            if (req[i] && i != low) high = i; // last hit is the highest
        end
    endfunction

    function automatic cdb_pkg::cdb_entry_t make_entry(input int tag, input int data);
        cdb_pkg::cdb_entry_t e;
        e.valid = 1'b1;
        e.tag   = cdb_pkg::tag_width'(tag);
        e.data  = cdb_pkg::data_width'(data);
        return e;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < num_fu; i++) m_state[i] = cdb_pkg::slot_empty;
        for (int p = 0; p < cdb_ports; p++) begin
            m_port_slot[p] = -1;
            m_bus[p]       = '0;
        end
        for (int r = 0; r < cdb_pkg::num_phys_regs; r++) m_data[r] = '0;
        m_rdy = '1; // all ready with data 0
        m_ovf = '0;
    endtask

    task automatic value_error(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    task automatic check_cdb(input int port, input cdb_pkg::cdb_entry_t got,
                             input cdb_pkg::cdb_entry_t exp);
        checks++;
        if (got !== exp) value_error($sformatf("cdb port %0d got %h, expected %h", port, got, exp));
    endtask

    task automatic check_early(input int port, input cdb_pkg::early_tag_t got,
                               input cdb_pkg::early_tag_t exp);
        checks++;
        if (got !== exp) value_error($sformatf("early tag %0d got %h, expected %h", port, got, exp));
    endtask

    task automatic check_read(input logic [cdb_pkg::data_width-1:0] got_data, input logic got_rdy,
                              input logic [cdb_pkg::data_width-1:0] exp_data, input logic exp_rdy);
        checks++;
        if (got_data !== exp_data || got_rdy !== exp_rdy) begin
            value_error($sformatf("read got %h ready %b, expected %h ready %b",
                                  got_data, got_rdy, exp_data, exp_rdy));
        end
    endtask

    task automatic check_overflow(input logic [num_fu-1:0] got, input logic [num_fu-1:0] exp);
        checks++;
        if (got !== exp) value_error($sformatf("overflow got %b, expected %b", got, exp));
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors so far", tests, name, errors);
    endtask

    // strobe one slot on the coming edge
    task automatic put_result(input int slot, input int tag, input int data);
        fu_strobe[slot]      <= 1'b1;
        fu_result[slot].tag  <= cdb_pkg::tag_width'(tag);
        fu_result[slot].data <= cdb_pkg::data_width'(data);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            fu_strobe    <= '0;
            alloc_strobe <= 1'b0;
        end
    endtask

    // compare at the falling edge, then step the model to the next rising edge
    always @(negedge clock) begin : compare
        logic [num_fu-1:0]   req;
        int                  pick [cdb_ports];
        cdb_pkg::cdb_entry_t drive [cdb_ports];
        cdb_pkg::early_tag_t exp_early;
        for (int i = 0; i < num_fu; i++) req[i] = (m_state[i] == cdb_pkg::slot_waiting);
        for (int p = 0; p < cdb_ports; p++) begin
            drive[p] = '0;
            if (m_port_slot[p] >= 0) begin
                drive[p] = make_entry(m_held[m_port_slot[p]].tag, m_held[m_port_slot[p]].data);
            end
            exp_early.valid = drive[p].valid;
            exp_early.tag   = drive[p].tag;
            check_early(p, early_tags[p], exp_early);
            check_cdb(p, cdb_output[p], m_bus[p]);
        end
        check_read(read_data, read_ready, m_data[read_tag], m_rdy[read_tag]);
        check_overflow(overflow, m_ovf);
        if (reset) begin
            reset_model();
        end else begin
            if (alloc_strobe) m_rdy[alloc_tag] = 1'b0;
            for (int p = 0; p < cdb_ports; p++) begin
                if (m_bus[p].valid) begin // write applied after alloc, so it wins
                    m_data[m_bus[p].tag] = m_bus[p].data;
                    m_rdy[m_bus[p].tag]  = 1'b1;
                end
            end
            pick_slots(req, pick[0], pick[1]);
            for (int i = 0; i < num_fu; i++) begin
                if (fu_strobe[i] && m_state[i] != cdb_pkg::slot_empty) m_ovf[i] = 1'b1;
                if (m_state[i] == cdb_pkg::slot_empty && fu_strobe[i]) begin
                    m_state[i] = cdb_pkg::slot_waiting;
                    m_held[i]  = fu_result[i];
                end else if (m_state[i] == cdb_pkg::slot_waiting) begin
                    if (i == pick[0] || i == pick[1]) m_state[i] = cdb_pkg::slot_driving;
                end else if (m_state[i] == cdb_pkg::slot_driving) begin
                    m_state[i] = cdb_pkg::slot_empty;
                end
            end
            for (int p = 0; p < cdb_ports; p++) begin
                m_bus[p]       = drive[p];
                m_port_slot[p] = pick[p];
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int lat_early;
        int lat_bus;
        int pairs;
        void'($urandom(7392));
        errors       = 0;
        checks       = 0;
        tests        = 0;
        cycles       = 0;
        clock        = 1'b0;
        reset        = 1'b1;
        fu_strobe    = '0;
        fu_result    = '0;
        alloc_strobe = 1'b0;
        alloc_tag    = '0;
        read_tag     = '0;
        reset_model();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        // single result, tag 10 allocated first so ready must rise again
        @(posedge clock);
        alloc_strobe <= 1'b1;
        alloc_tag    <= 6'd10;
        read_tag     <= 6'd10;
        @(posedge clock);
        alloc_strobe <= 1'b0;
        put_result(3, 10, 32'hcafe_0003);
        lat_early = -1;
        lat_bus   = -1;
        // n = 0 is the cycle the strobe is driven in
        for (int n = 0; n < 8; n++) begin
            @(negedge clock);
            if (lat_early < 0 && early_tags[0].valid) lat_early = n;
            if (lat_bus < 0 && cdb_output[0].valid) lat_bus = n;
            if (n == 3) check_read(read_data, read_ready, '0, 1'b0); // not yet written
            if (n == 4) check_read(read_data, read_ready, 32'hcafe_0003, 1'b1);
            @(posedge clock);
            fu_strobe <= '0;
        end
        if (lat_early != 2) value_error($sformatf("early tag after %0d, expected 2", lat_early));
        if (lat_bus != 3) value_error($sformatf("bus entry after %0d, expected 3", lat_bus));
        finish_test("single result latency");

        // all six at once, pairs drain from both ends
        for (int i = 0; i < num_fu; i++) put_result(i, 20 + i, 32'h1000 + i);
        pairs = 0;
        for (int n = 0; n < 12 && pairs < 3; n++) begin
            @(negedge clock);
            if (cdb_output[0].valid) begin
                check_cdb(0, cdb_output[0], make_entry(20 + pairs, 32'h1000 + pairs));
                check_cdb(1, cdb_output[1], make_entry(25 - pairs, 32'h1005 - pairs));
                pairs++;
            end
            @(posedge clock);
            fu_strobe <= '0;
        end
        if (pairs != 3) begin
            errors++;
            $display("only %0d of 3 result pairs reached the bus", pairs);
        end
        finish_test("two-ended priority");

        // slot 2 hit while waiting, slot 4 hit while driving
        put_result(2, 40, 32'h2222_0001);
        put_result(4, 41, 32'h4444_0001);
        @(posedge clock);
        fu_strobe <= '0;
        put_result(2, 42, 32'hdead_0002);
        @(posedge clock);
        fu_strobe <= '0;
        put_result(4, 43, 32'hdead_0004);
        idle(6);
        @(negedge clock);
        check_overflow(overflow, 6'b010100);
        finish_test("overflow");

        // alloc clears ready, write-back sets it
        @(posedge clock);
        alloc_strobe <= 1'b1;
        alloc_tag    <= 6'd33;
        read_tag     <= 6'd33;
        @(posedge clock);
        alloc_strobe <= 1'b0;
        @(negedge clock);
        check_read(read_data, read_ready, '0, 1'b0);
        @(posedge clock);
        put_result(1, 33, 32'h3333_0001);
        idle(4);
        @(negedge clock);
        check_read(read_data, read_ready, 32'h3333_0001, 1'b1);
        // alloc lands on the edge that writes tag 33
        @(posedge clock);
        put_result(1, 33, 32'h3333_0002);
        idle(2);
        @(posedge clock);
        alloc_strobe <= 1'b1;
        alloc_tag    <= 6'd33;
        idle(3);
        @(negedge clock);
        check_read(read_data, read_ready, 32'h3333_0002, 1'b1);
        finish_test("allocation and write-back");

        // random traffic, tag low bits = slot so in-flight tags never collide
        for (int n = 0; n < random_cycles; n++) begin
            @(posedge clock);
            fu_strobe    <= '0;
            alloc_strobe <= ($urandom % 4 == 0);
            alloc_tag    <= 6'($urandom);
            read_tag     <= 6'($urandom);
            for (int i = 0; i < num_fu; i++) begin
                if ($urandom % 3 == 0) put_result(i, ($urandom % 8) * 8 + i, $urandom);
            end
        end
        idle(12);
        finish_test("random traffic");

        errors = errors + i_cdb_top.i_cdb.i_cdb_assertions.failures;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
